// ==== verilog/smc_mac_cfg.svh ====
`ifndef SMC_MAC_CFG_SVH
`define SMC_MAC_CFG_SVH

// ---------------------------------------------------------------------------
// widths for the byte-serial memory access controller
// ---------------------------------------------------------------------------

// internal data word, one AHB-side transfer
`define SMC_WORD_W   32

// external memory data bus, 8-bit only
`define SMC_BYTE_W   8

// access counter, holds up to three further accesses
`define SMC_CNT_W    2

// one-hot sequencer state code
`define SMC_STATE_W  5

`endif

// ==== verilog/smc_mac_pkg.sv ====
`default_nettype none

`include "smc_mac_cfg.svh"

package smc_mac_pkg;

  // ---------------------------------------------------------------------------
  // data path vectors
  // ---------------------------------------------------------------------------

  typedef logic [`SMC_WORD_W-1:0] word_t;     // internal bus word
  typedef logic [`SMC_BYTE_W-1:0] byte_t;     // external bus byte
  typedef logic [`SMC_CNT_W-1:0]  acc_cnt_t;  // accesses left after current one

  // transfer size, same coding as the internal bus size field
  typedef enum logic [1:0]
  {
    XSIZ_8    = 2'd0,
    XSIZ_16   = 2'd1,
    XSIZ_32   = 2'd2,
    XSIZ_RSVD = 2'd3   // reserved, runs as a byte transfer
  } xfer_size_t;

  // sequencer next state, one-hot
  typedef enum logic [`SMC_STATE_W-1:0]
  {
    SMC_IDLE  = 5'b00001,
    SMC_LE    = 5'b00010,  // address latch enable
    SMC_RW    = 5'b00100,  // read or write strobe
    SMC_STORE = 5'b01000,
    SMC_FLOAT = 5'b10000   // bus turnaround
  } smc_state_t;

endpackage

`default_nettype wire

// ==== verilog/smc_access_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module smc_access_counter
(
  input  wire                      sys_clk10,
  input  wire                      n_sys_reset10,  // async, active low
  input  wire                      valid_access,   // address cycle of new transfer
  input  wire smc_mac_pkg::xfer_size_t xfer_size,  // valid with valid_access
  input  wire                      smc_done,       // sequencer end of access
  input  wire smc_mac_pkg::smc_state_t smc_nextstate,
  output smc_mac_pkg::xfer_size_t  r_xfer_size,    // stored size of transfer
  output smc_mac_pkg::xfer_size_t  v_xfer_size,    // size valid in any cycle
  output smc_mac_pkg::acc_cnt_t    r_num_access,   // accesses still to run
  output logic                     mac_done        // last access under way
);

  smc_mac_pkg::acc_cnt_t num_accesses;  // decoded load value
  logic                  count_step;    // qualified done strobe

  // ---------------------------------------------------------------------------
  // transfer size store
  // ---------------------------------------------------------------------------

  always_ff @(posedge sys_clk10 or negedge n_sys_reset10)
  begin
    if (!n_sys_reset10)
    begin
      r_xfer_size <= smc_mac_pkg::XSIZ_8;
    end
    else if (valid_access)
    begin
      r_xfer_size <= xfer_size;   // held until next address cycle
    end
  end

  // live size during the address cycle, stored size after it
  assign v_xfer_size = valid_access ? xfer_size : r_xfer_size;

  // ---------------------------------------------------------------------------
  // access count decode
  // ---------------------------------------------------------------------------

  always_comb
  begin
    case (xfer_size)
      smc_mac_pkg::XSIZ_32 : num_accesses = 2'd3;  // four byte accesses
      smc_mac_pkg::XSIZ_16 : num_accesses = 2'd1;  // two byte accesses
      default              : num_accesses = 2'd0;  // byte or reserved, one access
    endcase
  end

  // only accesses that move on to another bus cycle count
  assign count_step = smc_done
                      && (smc_nextstate != smc_mac_pkg::SMC_STORE)
                      && (smc_nextstate != smc_mac_pkg::SMC_IDLE);

  // ---------------------------------------------------------------------------
  // countdown
  // ---------------------------------------------------------------------------

  always_ff @(posedge sys_clk10 or negedge n_sys_reset10)
  begin
    if (!n_sys_reset10)
    begin
      r_num_access <= '0;
    end
    else if (valid_access)
    begin
      r_num_access <= num_accesses;   // load wins over a step
    end
    else if (count_step)
    begin
      r_num_access <= r_num_access - smc_mac_pkg::acc_cnt_t'(1);
    end
    // no done strobe, count holds
  end

  // zero count means the current access is the last one
  assign mac_done = (r_num_access == '0);

endmodule

`default_nettype wire

// ==== verilog/smc_read_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module smc_read_assembler
(
  input  wire                          sys_clk10,
  input  wire                          n_sys_reset10,  // async, active low
  input  wire                          latch_data,     // external byte valid
  input  wire smc_mac_pkg::byte_t      data_smc,       // external read byte
  input  wire smc_mac_pkg::acc_cnt_t   r_num_access,   // selects the store lane
  input  wire smc_mac_pkg::xfer_size_t r_xfer_size,    // stored size of transfer
  output smc_mac_pkg::word_t           read_data       // word to internal bus
);

  smc_mac_pkg::word_t r_read_data;  // byte store

  // store lanes, lane 3 is most significant
  smc_mac_pkg::byte_t st_b3;
  smc_mac_pkg::byte_t st_b2;
  smc_mac_pkg::byte_t st_b1;
  smc_mac_pkg::byte_t st_b0;

  // ---------------------------------------------------------------------------
  // read byte store
  // ---------------------------------------------------------------------------

  // first byte of a transfer lands highest, so the count names the lane
  always_ff @(posedge sys_clk10 or negedge n_sys_reset10)
  begin
    if (!n_sys_reset10)
    begin
      r_read_data <= '0;
    end
    else if (latch_data)
    begin
      case (r_num_access)
        2'd3 :
        begin
          r_read_data[31:24] <= data_smc;
          r_read_data[23:0]  <= '0;     // clear stale lanes of last word
        end
        2'd2 :
        begin
          r_read_data[23:16] <= data_smc;
          r_read_data[15:0]  <= '0;
        end
        2'd1 :
        begin
          r_read_data[15:8] <= data_smc;  // upper byte of a halfword too
        end
        default :
        begin
          r_read_data[7:0] <= data_smc;
        end
      endcase
    end
  end

  assign st_b3 = r_read_data[31:24];
  assign st_b2 = r_read_data[23:16];
  assign st_b1 = r_read_data[15:8];
  assign st_b0 = r_read_data[7:0];

  // ---------------------------------------------------------------------------
  // read word mux
  // ---------------------------------------------------------------------------

  // live byte bypasses the store in the latch cycle, narrow sizes replicate
  always_comb
  begin
    case (r_xfer_size)
      smc_mac_pkg::XSIZ_32 :
      begin
        if (latch_data)
        begin
          read_data = {st_b3, st_b2, st_b1, data_smc};
        end
        else
        begin
          read_data = r_read_data;
        end
      end
      smc_mac_pkg::XSIZ_16 :
      begin
        if (latch_data)
        begin
          read_data = {st_b1, data_smc, st_b1, data_smc};  // halfword in both halves
        end
        else
        begin
          read_data = {st_b1, st_b0, st_b1, st_b0};
        end
      end
      default :   // byte or reserved size
      begin
        if (latch_data)
        begin
          read_data = {4{data_smc}};
        end
        else
        begin
          read_data = {4{st_b0}};
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/smc_write_lane_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module smc_write_lane_sel
(
  input  wire smc_mac_pkg::word_t     write_data,    // held by the bus for all accesses
  input  wire smc_mac_pkg::acc_cnt_t  r_num_access,  // accesses still to run
  output smc_mac_pkg::byte_t          smc_data       // byte to external bus
);

  // ---------------------------------------------------------------------------
  // write byte select
  // ---------------------------------------------------------------------------

  // most significant byte first, a halfword starts at count 1
  always_comb
  begin
    case (r_num_access)
      2'd3 :
      begin
        smc_data = write_data[31:24];
      end
      2'd2 :
      begin
        smc_data = write_data[23:16];
      end
      2'd1 :
      begin
        smc_data = write_data[15:8];   // upper byte of halfword
      end
      default :
      begin
        smc_data = write_data[7:0];    // last access, or a single byte
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/smc_mac_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

module smc_mac_lite
(
  input  wire                          sys_clk10,
  input  wire                          n_sys_reset10,  // async, active low
  input  wire                          valid_access,   // address cycle of new transfer
  input  wire smc_mac_pkg::xfer_size_t xfer_size,      // valid with valid_access
  input  wire                          smc_done,       // sequencer end of access
  input  wire smc_mac_pkg::smc_state_t smc_nextstate,  // sequencer next state
  input  wire                          latch_data,     // external read byte valid
  input  wire smc_mac_pkg::byte_t      data_smc,       // external read byte
  input  wire smc_mac_pkg::word_t      write_data,     // internal write word
  output wire smc_mac_pkg::acc_cnt_t   r_num_access,   // access counter
  output wire                          mac_done,       // last access flag
  output wire smc_mac_pkg::xfer_size_t v_xfer_size,    // current transfer size
  output wire smc_mac_pkg::word_t      read_data,      // word to internal bus
  output wire smc_mac_pkg::byte_t      smc_data        // external write byte
);

  wire smc_mac_pkg::xfer_size_t r_xfer_size;  // stored size for read mux

  // ---------------------------------------------------------------------------
  // size and count stage
  // ---------------------------------------------------------------------------

  smc_access_counter i_smc_access_counter
  (
    .sys_clk10     (sys_clk10),
    .n_sys_reset10 (n_sys_reset10),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .r_xfer_size   (r_xfer_size),
    .v_xfer_size   (v_xfer_size),
    .r_num_access  (r_num_access),
    .mac_done      (mac_done)
  );

  // ---------------------------------------------------------------------------
  // read assembly and write lane stages
  // ---------------------------------------------------------------------------

  smc_read_assembler i_smc_read_assembler
  (
    .sys_clk10     (sys_clk10),
    .n_sys_reset10 (n_sys_reset10),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .r_num_access  (r_num_access),
    .r_xfer_size   (r_xfer_size),
    .read_data     (read_data)
  );

  // count alone picks the lane, size is implied by the load value
  smc_write_lane_sel i_smc_write_lane_sel
  (
    .write_data    (write_data),
    .r_num_access  (r_num_access),
    .smc_data      (smc_data)
  );

endmodule

`default_nettype wire

// ==== tests/smc_mac_lite_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module smc_mac_lite_sva
(
  input wire                          sys_clk10,
  input wire                          n_sys_reset10,
  input wire                          valid_access,
  input wire smc_mac_pkg::xfer_size_t xfer_size,
  input wire                          smc_done,
  input wire smc_mac_pkg::smc_state_t smc_nextstate,
  input wire smc_mac_pkg::acc_cnt_t   r_num_access,
  input wire                          mac_done
);

  wire count_step;          // done strobe that moves the count
  integer fail_cnt = 0;     // assertion failures so far

  assign count_step = smc_done
                      && (smc_nextstate != smc_mac_pkg::SMC_STORE)
                      && (smc_nextstate != smc_mac_pkg::SMC_IDLE);

  // ---------------------------------------------------------------------------
  // counter properties
  // ---------------------------------------------------------------------------

  a_done_is_zero : assert property (@(posedge sys_clk10) disable iff (!n_sys_reset10)
    mac_done == (r_num_access == '0))
    else
    begin
      $error("mac_done disagrees with a zero access count");
      fail_cnt = fail_cnt + 1;
    end

  // no load, no step, no change
  a_count_holds : assert property (@(posedge sys_clk10) disable iff (!n_sys_reset10)
    (!valid_access && !count_step) |=> $stable(r_num_access))
    else
    begin
      $error("access count moved without a load or a done strobe");
      fail_cnt = fail_cnt + 1;
    end

  a_word_load : assert property (@(posedge sys_clk10) disable iff (!n_sys_reset10)
    (valid_access && (xfer_size == smc_mac_pkg::XSIZ_32)) |=> (r_num_access == 2'd3))
    else
    begin
      $error("word transfer did not load a count of 3");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind smc_mac_lite smc_mac_lite_sva i_smc_mac_lite_sva
(
  .sys_clk10     (sys_clk10),
  .n_sys_reset10 (n_sys_reset10),
  .valid_access  (valid_access),
  .xfer_size     (xfer_size),
  .smc_done      (smc_done),
  .smc_nextstate (smc_nextstate),
  .r_num_access  (r_num_access),
  .mac_done      (mac_done)
);

`default_nettype wire

// ==== tests/tb_smc_mac_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_smc_mac_lite;

  localparam integer NUM_XFERS       = 200;
  localparam integer CYCLES_PER_XFER = 40;   // generous bound per transfer
  localparam integer RESET_CYCLES    = 16;
  localparam integer TIMEOUT_CYCLES  = NUM_XFERS * CYCLES_PER_XFER + RESET_CYCLES;
  localparam integer DRIVE_DELAY     = 10;   // ns after rising edge

  logic                          sys_clk10;
  logic                          n_sys_reset10;
  logic                          valid_access;
  smc_mac_pkg::xfer_size_t       xfer_size;
  logic                          smc_done;
  smc_mac_pkg::smc_state_t       smc_nextstate;
  logic                          latch_data;
  smc_mac_pkg::byte_t            data_smc;
  smc_mac_pkg::word_t            write_data;
  wire smc_mac_pkg::acc_cnt_t    r_num_access;
  wire                           mac_done;
  wire smc_mac_pkg::xfer_size_t  v_xfer_size;
  wire smc_mac_pkg::word_t       read_data;
  wire smc_mac_pkg::byte_t       smc_data;

  integer seed = 32'ha8f8_f535;
  integer cycle_cnt = 0;
  integer check_cnt = 0;
  integer err_cnt = 0;
  integer read_cnt = 0;   // finished read words seen
  integer sva_fails;      // failed bound assertions
  integer test_errs;
  integer xfer;

  // reference model state
  smc_mac_pkg::xfer_size_t m_size;
  smc_mac_pkg::acc_cnt_t   m_cnt;
  smc_mac_pkg::word_t      m_store;

  smc_mac_lite i_smc_mac_lite
  (
    .sys_clk10     (sys_clk10),
    .n_sys_reset10 (n_sys_reset10),
    .valid_access  (valid_access),
    .xfer_size     (xfer_size),
    .smc_done      (smc_done),
    .smc_nextstate (smc_nextstate),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .write_data    (write_data),
    .r_num_access  (r_num_access),
    .mac_done      (mac_done),
    .v_xfer_size   (v_xfer_size),
    .read_data     (read_data),
    .smc_data      (smc_data)
  );

  initial
  begin
    sys_clk10 = 1'b0;
    forever #50 sys_clk10 = ~sys_clk10;   // 100 ns period
  end

  // hard stop if a transfer never finishes
  always @(posedge sys_clk10)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------

  task draw_word(output logic [31:0] v);
    begin
      v = $random(seed);
    end
  endtask

  function automatic smc_mac_pkg::smc_state_t state_from_index(input integer idx);
    case (idx)
      0       : state_from_index = smc_mac_pkg::SMC_IDLE;
      1       : state_from_index = smc_mac_pkg::SMC_LE;
      2       : state_from_index = smc_mac_pkg::SMC_RW;
      3       : state_from_index = smc_mac_pkg::SMC_STORE;
      default : state_from_index = smc_mac_pkg::SMC_FLOAT;
    endcase
  endfunction

  task flag_mismatch(input string msg);
    begin
      $display("[ERROR] %0d ns: %s", $time, msg);
      err_cnt = err_cnt + 1;
    end
  endtask

  // compare all combinational outputs against the model mid-cycle
  task check_outputs;
    smc_mac_pkg::word_t      exp_rd;
    smc_mac_pkg::xfer_size_t exp_sz;
    smc_mac_pkg::byte_t      exp_wr;
    begin
      check_cnt = check_cnt + 1;
      exp_sz = valid_access ? xfer_size : m_size;
      exp_wr = write_data[m_cnt * 8 +: 8];   // count picks the lane
      if (r_num_access !== m_cnt)
        flag_mismatch($sformatf("r_num_access got %0d, expected %0d", r_num_access, m_cnt));
      if (mac_done !== (m_cnt == 2'd0))
        flag_mismatch($sformatf("mac_done got %0b with count %0d", mac_done, m_cnt));
      if (v_xfer_size !== exp_sz)
        flag_mismatch($sformatf("v_xfer_size got %0d, expected %0d", v_xfer_size, exp_sz));
      if (smc_data !== exp_wr)
        flag_mismatch($sformatf("smc_data got %02h, expected %02h", smc_data, exp_wr));
      if (latch_data && (m_cnt == 2'd0))   // last byte of a read
      begin
        case (m_size)
          smc_mac_pkg::XSIZ_32 : exp_rd = {m_store[31:8], data_smc};
          smc_mac_pkg::XSIZ_16 : exp_rd = {m_store[15:8], data_smc, m_store[15:8], data_smc};
          default              : exp_rd = {4{data_smc}};
        endcase
        read_cnt = read_cnt + 1;
        if (read_data !== exp_rd)
          flag_mismatch($sformatf("read_data got %08h, expected %08h", read_data, exp_rd));
      end
    end
  endtask

  // model step on the rising edge where inputs are stable
  task update_model;
    begin
      if (latch_data)
      begin
        case (m_cnt)
          2'd3    : m_store = {data_smc, 24'h0};   // first byte clears the lower lanes
          2'd2    : m_store = {m_store[31:24], data_smc, 16'h0};
          2'd1    : m_store[15:8] = data_smc;
          default : m_store[7:0] = data_smc;
        endcase
      end
      if (valid_access)
      begin
        m_size = xfer_size;
        case (xfer_size)
          smc_mac_pkg::XSIZ_32 : m_cnt = 2'd3;
          smc_mac_pkg::XSIZ_16 : m_cnt = 2'd1;
          default              : m_cnt = 2'd0;
        endcase
      end
      else if (smc_done && (smc_nextstate != smc_mac_pkg::SMC_STORE)
               && (smc_nextstate != smc_mac_pkg::SMC_IDLE))
      begin
        m_cnt = m_cnt - 2'd1;   // wraps like the 2-bit counter
      end
    end
  endtask

  task clock_cycle;
    begin
      @(negedge sys_clk10);
      check_outputs;
      @(posedge sys_clk10);
      update_model;
      #DRIVE_DELAY;
    end
  endtask

  // ---------------------------------------------------------------------------
  // one transfer of address cycle, idle gaps and byte accesses
  // ---------------------------------------------------------------------------

  task run_transfer;
    logic [31:0] r;
    integer      gaps;
    logic        finished;
    begin
      draw_word(r);
      write_data = r;                        // held for the whole transfer
      draw_word(r);
      xfer_size = smc_mac_pkg::xfer_size_t'(r[7:0] % 3);
      valid_access = 1'b1;
      smc_done = r[16];                      // a stray strobe must lose to the load
      smc_nextstate = state_from_index(r[14:12] % 5);
      latch_data = smc_done && (smc_nextstate == smc_mac_pkg::SMC_RW);
      data_smc = r[31:24];
      clock_cycle;
      valid_access = 1'b0;
      smc_done = 1'b0;
      latch_data = 1'b0;
      draw_word(r);
      gaps = r[1:0];
      repeat (gaps)
      begin
        draw_word(r);
        xfer_size = smc_mac_pkg::xfer_size_t'(r[9:8]);   // ignored while the size is held
        data_smc = r[31:24];
        clock_cycle;
      end
      finished = 1'b0;
      while (!finished)
      begin
        draw_word(r);
        xfer_size = smc_mac_pkg::xfer_size_t'(r[9:8]);
        if (m_cnt == 2'd0)   // last access reads the final byte
        begin
          smc_done = 1'b1;
          smc_nextstate = smc_mac_pkg::SMC_RW;
          finished = 1'b1;
        end
        else
        begin
          smc_done = (r[1:0] != 2'd0);
          smc_nextstate = state_from_index(r[6:4] % 5);
        end
        latch_data = smc_done && (smc_nextstate == smc_mac_pkg::SMC_RW);
        data_smc = r[31:24];
        clock_cycle;
      end
      smc_done = 1'b0;
      latch_data = 1'b0;
      smc_nextstate = smc_mac_pkg::SMC_IDLE;
    end
  endtask

  // ---------------------------------------------------------------------------
  // main sequence
  // ---------------------------------------------------------------------------

  initial
  begin
    n_sys_reset10 = 1'b0;
    valid_access = 1'b0;
    xfer_size = smc_mac_pkg::XSIZ_8;
    smc_done = 1'b0;
    smc_nextstate = smc_mac_pkg::SMC_IDLE;
    latch_data = 1'b0;
    data_smc = '0;
    write_data = '0;
    m_size = smc_mac_pkg::XSIZ_8;   // model reset state
    m_cnt = '0;
    m_store = '0;

    repeat (RESET_CYCLES) @(posedge sys_clk10);
    #DRIVE_DELAY;
    n_sys_reset10 = 1'b1;

    // reset state
    test_errs = err_cnt;
    @(negedge sys_clk10);
    check_cnt = check_cnt + 1;
    if (mac_done !== 1'b1)
      flag_mismatch($sformatf("mac_done after reset got %0b, expected 1", mac_done));
    if (r_num_access !== 2'd0)
      flag_mismatch($sformatf("r_num_access after reset got %0d, expected 0", r_num_access));
    if (v_xfer_size !== smc_mac_pkg::XSIZ_8)
      flag_mismatch($sformatf("v_xfer_size after reset got %0d, expected 0", v_xfer_size));
    if (read_data !== 32'h0)
      flag_mismatch($sformatf("read_data after reset got %08h, expected 0", read_data));
    $display("test reset_state finished, %0d errors", err_cnt - test_errs);
    @(posedge sys_clk10);
    #DRIVE_DELAY;

    // random transfers
    test_errs = err_cnt;
    for (xfer = 0; xfer < NUM_XFERS; xfer = xfer + 1)
      run_transfer;
    $display("test random_transfers finished, %0d transfers, %0d errors",
             NUM_XFERS, err_cnt - test_errs);

    sva_fails = i_smc_mac_lite.i_smc_mac_lite_sva.fail_cnt;
    $display("summary: %0d checks, %0d read words, %0d errors, %0d assertion failures",
             check_cnt, read_cnt, err_cnt, sva_fails);
    if ((err_cnt == 0) && (sva_fails == 0))
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== smc_mac_lite.f ====
+incdir+verilog
verilog/smc_mac_pkg.sv
verilog/smc_access_counter.sv
verilog/smc_read_assembler.sv
verilog/smc_write_lane_sel.sv
verilog/smc_mac_lite.sv
tests/smc_mac_lite_sva.sv
tests/tb_smc_mac_lite.sv
